//--- include/vga_consts.svh
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// Bus widths and control word layout
`define VGA_BUS_WIDTH      32
`define VGA_CTRL_WIDTH     8
`define VGA_CTRL_WRITE_BIT 1

// Horizontal timing in pixel clocks, 640x480 at 60 Hz
`define VGA_H_ACTIVE 640
`define VGA_H_FRONT  16
`define VGA_H_SYNC   96
`define VGA_H_BACK   48
`define VGA_H_TOTAL  800

// Vertical timing in lines
`define VGA_V_ACTIVE 480
`define VGA_V_FRONT  10
`define VGA_V_SYNC   2
`define VGA_V_BACK   33
`define VGA_V_TOTAL  525

// Framebuffer geometry, one byte per stored pixel
`define VGA_FB_WIDTH  160
`define VGA_FB_HEIGHT 120
`define VGA_FB_DEPTH  19200

// Bus word layout: address above, RGB332 pixel in the low byte
`define VGA_ADDR_LSB 8
`define VGA_ADDR_MSB 22

`endif

//--- hdl/vgaPkg.sv
`default_nettype none

package vgaPkg;

    `include "vga_consts.svh"

    // Bus side words
    typedef logic [`VGA_BUS_WIDTH-1:0] busWord_t;
    typedef logic [`VGA_CTRL_WIDTH-1:0] busCtrl_t;

    // Framebuffer address field, bits 22 down to 8 of the bus word
    typedef logic [`VGA_ADDR_MSB-`VGA_ADDR_LSB:0] fbAddr_t;

    // RGB332 pixel, the bits below the address field
    typedef logic [`VGA_ADDR_LSB-1:0] pixel_t;

    // Screen counters and coordinates, up to 799
    typedef logic [9:0] screenCoord_t;

    // Bus slave sequence, read states dropped
    typedef enum logic [1:0] {
        Idle,
        WriteWait,
        WriteData,
        Finish
    } slaveState_t;

endpackage

`default_nettype wire

//--- hdl/vgaSlaveInterface.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_consts.svh"

module vgaSlaveInterface
    import vgaPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  busWord_t busIn,
    input  busCtrl_t ctrlIn,
    input  logic     ack,
    output logic     dataWe,
    output fbAddr_t  wrAddr,
    output pixel_t   wrPixel
);

    slaveState_t state;
    slaveState_t nextState;

    logic writeReq;
    logic startWrite;

    // Write bit of the control word, only looked at while ack is high
    assign writeReq = ctrlIn[`VGA_CTRL_WRITE_BIT];

    // A transfer starts only from Idle, so a long ack cannot retrigger
    assign startWrite = (state == Idle) && ack && writeReq;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // Next state decode
    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                // Ack without the write bit is accepted and dropped here
                if (startWrite) begin
                    nextState = WriteWait;
                end
            end
            WriteWait: begin
                nextState = WriteData;
            end
            WriteData: begin
                nextState = Finish;
            end
            Finish: begin
                // Hold until the master releases ack
                if (!ack) begin
                    nextState = Idle;
                end
            end
            default: begin
                nextState = Idle;
            end
        endcase
    end

    // Address and pixel latched when leaving Idle, stable through WriteData
    always_ff @(posedge clk) begin
        if (startWrite) begin
            wrAddr  <= busIn[`VGA_ADDR_MSB:`VGA_ADDR_LSB];
            wrPixel <= busIn[`VGA_ADDR_LSB-1:0];
        end
    end

    // One-cycle write strobe
    assign dataWe = (state == WriteData);

    // One strobe per transfer, even with ack held high
    assert property (@(posedge clk) disable iff (!arstN)
        dataWe |=> !dataWe)
        else $error("dataWe high for two consecutive cycles");

    // Finish is left as soon as ack drops
    assert property (@(posedge clk) disable iff (!arstN)
        (state == Finish) && !ack |=> (state == Idle))
        else $error("slave did not return to Idle after ack dropped");

endmodule

`default_nettype wire

//--- hdl/vgaTiming.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_consts.svh"

module vgaTiming
    import vgaPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    output screenCoord_t pixelX,
    output screenCoord_t pixelY,
    output logic         hsyncRaw,
    output logic         vsyncRaw,
    output logic         activeRaw
);

    // Sync pulse boundaries, counted from the start of the active area
    localparam int HSyncStart = `VGA_H_ACTIVE + `VGA_H_FRONT;
    localparam int HSyncEnd   = HSyncStart + `VGA_H_SYNC;
    localparam int VSyncStart = `VGA_V_ACTIVE + `VGA_V_FRONT;
    localparam int VSyncEnd   = VSyncStart + `VGA_V_SYNC;

    localparam screenCoord_t HLast = screenCoord_t'(`VGA_H_TOTAL - 1);
    localparam screenCoord_t VLast = screenCoord_t'(`VGA_V_TOTAL - 1);

    screenCoord_t hCount;
    screenCoord_t vCount;

    logic lineEnd;

    assign lineEnd = (hCount == HLast);

    // Horizontal counter, one pixel per clock with no stalls
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // Vertical counter steps once per line
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vCount <= '0;
        end else if (lineEnd) begin
            if (vCount == VLast) begin
                vCount <= '0;
            end else begin
                vCount <= vCount + 1'b1;
            end
        end
    end

    // Both syncs are active low
    assign hsyncRaw = !((hCount >= HSyncStart) && (hCount < HSyncEnd));
    assign vsyncRaw = !((vCount >= VSyncStart) && (vCount < VSyncEnd));

    assign activeRaw = (hCount < `VGA_H_ACTIVE) && (vCount < `VGA_V_ACTIVE);

    assign pixelX = hCount;
    assign pixelY = vCount;

    // Counters never leave the frame
    assert property (@(posedge clk) disable iff (!arstN)
        (hCount < `VGA_H_TOTAL) && (vCount < `VGA_V_TOTAL))
        else $error("timing counter out of range");

endmodule

`default_nettype wire

//--- hdl/vgaScanout.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_consts.svh"

module vgaScanout
    import vgaPkg::*;
(
    input  logic         clk,
    input  logic         arstN,
    input  logic         dataWe,
    input  fbAddr_t      wrAddr,
    input  pixel_t       wrPixel,
    input  screenCoord_t pixelX,
    input  screenCoord_t pixelY,
    input  logic         hsyncRaw,
    input  logic         vsyncRaw,
    input  logic         activeRaw,
    output logic         vgaHsync,
    output logic         vgaVsync,
    output logic         videoActive,
    output logic [2:0]   red,
    output logic [2:0]   green,
    output logic [1:0]   blue
);

    localparam fbAddr_t FbWidth = fbAddr_t'(`VGA_FB_WIDTH);

    pixel_t fbMem [0:`VGA_FB_DEPTH-1];

    fbAddr_t fbRow;
    fbAddr_t fbCol;
    fbAddr_t rdAddr;
    pixel_t  rdPixel;

    // Each stored pixel covers a 4x4 block of screen pixels
    assign fbRow = fbAddr_t'(pixelY >> 2);
    assign fbCol = fbAddr_t'(pixelX >> 2);

    // Park the read address at zero during blanking
    assign rdAddr = activeRaw ? fbAddr_t'(fbRow * FbWidth + fbCol) : '0;

    // Write port from the bus slave
    always_ff @(posedge clk) begin
        if (dataWe) begin
            fbMem[wrAddr] <= wrPixel;
        end
    end

    // Registered read port, data valid one cycle after the address
    always_ff @(posedge clk) begin
        rdPixel <= fbMem[rdAddr];
    end

    // Delay syncs and active flag to line up with the read data
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            vgaHsync    <= 1'b1;
            vgaVsync    <= 1'b1;
            videoActive <= 1'b0;
        end else begin
            vgaHsync    <= hsyncRaw;
            vgaVsync    <= vsyncRaw;
            videoActive <= activeRaw;
        end
    end

    // RGB332 split, black in blanking
    assign red   = videoActive ? rdPixel[7:5] : 3'b000;
    assign green = videoActive ? rdPixel[4:2] : 3'b000;
    assign blue  = videoActive ? rdPixel[1:0] : 2'b00;

    // No color leaks into the porches or sync pulses
    assert property (@(posedge clk) disable iff (!arstN)
        !videoActive |-> ({red, green, blue} == 8'h00))
        else $error("color driven outside active video");

endmodule

`default_nettype wire

//--- hdl/vgaController.sv
`timescale 1ns/1ps
`default_nettype none

module vgaController
    import vgaPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  busWord_t   busIn,
    input  busCtrl_t   ctrlIn,
    input  logic       ack,
    output logic       vgaHsync,
    output logic       vgaVsync,
    output logic       videoActive,
    output logic [2:0] red,
    output logic [2:0] green,
    output logic [1:0] blue
);

    // Slave to framebuffer write port
    logic    dataWe;
    fbAddr_t wrAddr;
    pixel_t  wrPixel;

    // Raster position and raw flags
    screenCoord_t pixelX;
    screenCoord_t pixelY;
    logic         hsyncRaw;
    logic         vsyncRaw;
    logic         activeRaw;

    vgaSlaveInterface i_vgaSlaveInterface (
        .clk     (clk),
        .arstN   (arstN),
        .busIn   (busIn),
        .ctrlIn  (ctrlIn),
        .ack     (ack),
        .dataWe  (dataWe),
        .wrAddr  (wrAddr),
        .wrPixel (wrPixel)
    );

    vgaTiming i_vgaTiming (
        .clk       (clk),
        .arstN     (arstN),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .hsyncRaw  (hsyncRaw),
        .vsyncRaw  (vsyncRaw),
        .activeRaw (activeRaw)
    );

    // Framebuffer sits between the bus and the raster
    vgaScanout i_vgaScanout (
        .clk         (clk),
        .arstN       (arstN),
        .dataWe      (dataWe),
        .wrAddr      (wrAddr),
        .wrPixel     (wrPixel),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .hsyncRaw    (hsyncRaw),
        .vsyncRaw    (vsyncRaw),
        .activeRaw   (activeRaw),
        .vgaHsync    (vgaHsync),
        .vgaVsync    (vgaVsync),
        .videoActive (videoActive),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

endmodule

`default_nettype wire

//--- tests/vgaControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vga_consts.svh"

module vgaControllerTb
    import vgaPkg::*;
();

    // Fill is about 96k cycles, the two captures end near 1.65M cycles
    localparam int TimeoutCycles   = 2500000;
    localparam int ScreenPixels    = `VGA_H_ACTIVE * `VGA_V_ACTIVE;
    localparam int ShownMismatches = 8;

    logic       clk = 1'b0;
    logic       arstN;
    busWord_t   busIn;
    busCtrl_t   ctrlIn;
    logic       ack;
    logic       vgaHsync;
    logic       vgaVsync;
    logic       videoActive;
    logic [2:0] red;
    logic [2:0] green;
    logic [1:0] blue;

    integer seed;
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;

    // Reference framebuffer and the last captured frame
    pixel_t     fbModel [0:`VGA_FB_DEPTH-1];
    logic [7:0] capPix [0:ScreenPixels-1];

    // Measurements of the last captured frame
    int capIdx;
    int blankNonzero;
    int lineLen;
    int hsyncWidth;
    int activeMin;
    int activeMax;
    int activeLines;
    int linesPerFrame;
    int vsyncLines;

    fbAddr_t ignoredAddr [0:3];
    fbAddr_t longAddr;
    pixel_t  longPixel;

    vgaController i_vgaController (
        .clk         (clk),
        .arstN       (arstN),
        .busIn       (busIn),
        .ctrlIn      (ctrlIn),
        .ack         (ack),
        .vgaHsync    (vgaHsync),
        .vgaVsync    (vgaVsync),
        .videoActive (videoActive),
        .red         (red),
        .green       (green),
        .blue        (blue)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount = checkCount + 1;
        if (expected !== actual) begin
            errorCount = errorCount + 1;
            $display("mismatch in %s: expected %0h, actual %0h", testName, expected, actual);
        end
    endtask

    // One transfer, ack high for a cycle then low for four
    task automatic busTransfer(input fbAddr_t addr, input pixel_t pixel, input logic write);
        busIn = '0;
        busIn[`VGA_ADDR_MSB:`VGA_ADDR_LSB] = addr;
        busIn[`VGA_ADDR_LSB-1:0] = pixel;
        ctrlIn = write ? '0 : '1;
        ctrlIn[`VGA_CTRL_WRITE_BIT] = write;
        ack = 1'b1;
        @(posedge clk);
        #1;
        ack = 1'b0;
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic busWrite(input fbAddr_t addr, input pixel_t pixel);
        busTransfer(addr, pixel, 1'b1);
    endtask

    task automatic busIgnored(input fbAddr_t addr, input pixel_t pixel);
        busTransfer(addr, pixel, 1'b0);
    endtask

    // Record one frame from a vsync falling edge to the next, sampled at negedge
    task automatic captureFrame;
        logic prevH;
        logic prevV;
        logic done;
        int   n;
        int   lastHFall;
        int   hLowRun;
        int   activeInLine;
        @(negedge clk);
        prevV = vgaVsync;
        @(negedge clk);
        while (!(prevV && !vgaVsync)) begin
            prevV = vgaVsync;
            @(negedge clk);
        end
        capIdx = 0;
        blankNonzero = 0;
        activeMin = 1 << 30;
        activeMax = 0;
        activeLines = 0;
        linesPerFrame = 0;
        vsyncLines = 0;
        lineLen = 0;
        hsyncWidth = 0;
        n = 0;
        lastHFall = -1;
        hLowRun = 0;
        activeInLine = 0;
        prevH = 1'b1;
        done = 1'b0;
        while (!done) begin
            if (prevH && !vgaHsync) begin
                if (lastHFall >= 0) begin
                    lineLen = n - lastHFall;
                end
                lastHFall = n;
                linesPerFrame = linesPerFrame + 1;
                if (!vgaVsync) begin
                    vsyncLines = vsyncLines + 1;
                end
                if (activeInLine > 0) begin
                    activeLines = activeLines + 1;
                    activeMin = (activeInLine < activeMin) ? activeInLine : activeMin;
                    activeMax = (activeInLine > activeMax) ? activeInLine : activeMax;
                end
                activeInLine = 0;
            end
            if (!prevH && vgaHsync) begin
                hsyncWidth = hLowRun;
                hLowRun = 0;
            end
            if (!vgaHsync) begin
                hLowRun = hLowRun + 1;
            end
            if (videoActive) begin
                if (capIdx < ScreenPixels) begin
                    capPix[capIdx] = {red, green, blue};
                end
                capIdx = capIdx + 1;
                activeInLine = activeInLine + 1;
            end else if ({red, green, blue} !== 8'h00) begin
                blankNonzero = blankNonzero + 1;
            end
            prevH = vgaHsync;
            prevV = vgaVsync;
            @(negedge clk);
            n = n + 1;
            done = prevV && !vgaVsync;
        end
    endtask

    // Every screen pixel shows the stored pixel of its 4x4 block
    task automatic compareFrame(input string testName);
        int         x;
        int         y;
        int         bad;
        logic [7:0] expected;
        bad = 0;
        checkValue(testName, ScreenPixels, capIdx);
        for (y = 0; y < `VGA_V_ACTIVE; y++) begin
            for (x = 0; x < `VGA_H_ACTIVE; x++) begin
                expected = fbModel[(y / 4) * `VGA_FB_WIDTH + x / 4];
                if (capPix[y * `VGA_H_ACTIVE + x] !== expected) begin
                    bad = bad + 1;
                    if (bad <= ShownMismatches) begin
                        checkValue(testName, expected, capPix[y * `VGA_H_ACTIVE + x]);
                    end else begin
                        errorCount = errorCount + 1;
                    end
                end
            end
        end
        if (bad > ShownMismatches) begin
            $display("%s: %0d more wrong pixels not listed", testName, bad - ShownMismatches);
        end
        checkValue(testName, 0, blankNonzero);
    endtask

    task automatic checkSyncTiming(input string testName);
        checkValue(testName, `VGA_H_TOTAL, lineLen);
        checkValue(testName, `VGA_H_SYNC, hsyncWidth);
        checkValue(testName, `VGA_H_ACTIVE, activeMin);
        checkValue(testName, `VGA_H_ACTIVE, activeMax);
        checkValue(testName, `VGA_V_ACTIVE, activeLines);
        checkValue(testName, `VGA_V_TOTAL, linesPerFrame);
        checkValue(testName, `VGA_V_SYNC, vsyncLines);
    endtask

    // Top-left screen pixel of the block that shows one framebuffer entry
    task automatic checkScreenPixel(input string testName, input fbAddr_t addr,
                                    input pixel_t expected);
        int sx;
        int sy;
        sx = (int'(addr) % `VGA_FB_WIDTH) * 4;
        sy = (int'(addr) / `VGA_FB_WIDTH) * 4;
        checkValue(testName, expected, capPix[sy * `VGA_H_ACTIVE + sx]);
    endtask

    task automatic resetState;
        @(posedge clk);
        #1;
        checkValue("resetState", 1, vgaHsync);
        checkValue("resetState", 1, vgaVsync);
        checkValue("resetState", 0, videoActive);
        checkValue("resetState", 0, {red, green, blue});
        @(posedge clk);
        #1;
        arstN = 1'b1;
        @(negedge clk);
        checkValue("resetRelease", 1, vgaHsync);
        checkValue("resetRelease", 1, vgaVsync);
        checkValue("resetRelease", 0, videoActive);
        checkValue("resetRelease", 0, {red, green, blue});
    endtask

    task automatic fillAndReadback;
        int a;
        @(posedge clk);
        #1;
        for (a = 0; a < `VGA_FB_DEPTH; a++) begin
            fbModel[a] = pixel_t'($random(seed));
            busWrite(fbAddr_t'(a), fbModel[a]);
        end
        captureFrame;
        compareFrame("fillReadback");
        checkSyncTiming("syncTiming");
    endtask

    // Model stays as it is, checked after the next capture
    task automatic ignoredTransfers;
        int i;
        ignoredAddr[0] = fbAddr_t'(1);
        ignoredAddr[1] = fbAddr_t'(160);
        ignoredAddr[2] = fbAddr_t'(9600);
        ignoredAddr[3] = fbAddr_t'(19199);
        @(posedge clk);
        #1;
        for (i = 0; i < 4; i++) begin
            busIgnored(ignoredAddr[i], ~fbModel[ignoredAddr[i]]);
        end
    endtask

    // Ack held 20 cycles with the pixel changed after the first
    task automatic longAckWrite;
        longAddr = fbAddr_t'(807);
        longPixel = fbModel[longAddr] ^ 8'h5a;
        @(posedge clk);
        #1;
        busIn = '0;
        busIn[`VGA_ADDR_MSB:`VGA_ADDR_LSB] = longAddr;
        busIn[`VGA_ADDR_LSB-1:0] = longPixel;
        ctrlIn = '0;
        ctrlIn[`VGA_CTRL_WRITE_BIT] = 1'b1;
        ack = 1'b1;
        @(posedge clk);
        #1;
        busIn[`VGA_ADDR_LSB-1:0] = ~longPixel;
        repeat (19) @(posedge clk);
        #1;
        ack = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        fbModel[longAddr] = longPixel;
    endtask

    task automatic writesDuringDisplay;
        int      i;
        fbAddr_t a;
        pixel_t  p;
        // Start once the current frame is on screen
        @(negedge clk);
        while (!videoActive) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        for (i = 0; i < 32; i++) begin
            a = fbAddr_t'(i * 601);
            p = pixel_t'($random(seed));
            fbModel[a] = p;
            busWrite(a, p);
        end
        captureFrame;
        compareFrame("displayWrites");
        checkSyncTiming("syncTimingAgain");
        for (i = 0; i < 4; i++) begin
            checkScreenPixel("ignoredTransfers", ignoredAddr[i], fbModel[ignoredAddr[i]]);
        end
        checkScreenPixel("longAckWrite", longAddr, longPixel);
    endtask

    initial begin
        arstN = 1'b0;
        busIn = '0;
        ctrlIn = '0;
        ack = 1'b0;
        seed = 32'h07c10b13;
        resetState;
        fillAndReadback;
        ignoredTransfers;
        longAckWrite;
        writesDuringDisplay;
        $display("errors: %0d over %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vgaController.f
+incdir+include
hdl/vgaPkg.sv
hdl/vgaSlaveInterface.sv
hdl/vgaTiming.sv
hdl/vgaScanout.sv
hdl/vgaController.sv
tests/vgaControllerTb.sv
